// File: hdl/payload_pkg.sv
package payload_pkg;

    // data layout of the encryption result

    localparam int BYTE_W = 8;

    // field lengths in bytes
    localparam int DEF_CIPHER_BYTES = 183;
    localparam int DEF_TAG_BYTES = 16;

    // width of a byte position, limits a field to 256 bytes
    localparam int INDEX_W = 8;

    typedef logic [INDEX_W-1:0] byte_index_t;

endpackage : payload_pkg

// File: hdl/readout_pkg.sv
package readout_pkg;

    // which field a read request names
    typedef enum logic
    {
        FIELD_CIPHER = 1'b0,
        FIELD_TAG    = 1'b1
    } field_e;

    typedef enum logic
    {
        ST_IDLE   = 1'b0,
        ST_STREAM = 1'b1
    } readout_state_e;

endpackage : readout_pkg

// File: hdl/byte_fetch_if.sv
interface byte_fetch_if;

    // byte request from the readout control
    readout_pkg::field_e        field;
    payload_pkg::byte_index_t   index;

    // high while no stream is running, writes allowed
    logic                       write_open;

    // selected byte, combinational from field and index
    logic [payload_pkg::BYTE_W-1:0] byte_data;

    modport ctrl
    (
        output field,
        output index,
        output write_open,
        input  byte_data
    );

    modport store
    (
        input  field,
        input  index,
        input  write_open,
        output byte_data
    );

endinterface : byte_fetch_if

// File: hdl/payload_store.sv
module payload_store
#(
    parameter int CIPHER_BYTES = payload_pkg::DEF_CIPHER_BYTES,
    parameter int TAG_BYTES    = payload_pkg::DEF_TAG_BYTES
)
(
    input  logic                                    clock_i,
    input  logic                                    reset_i,
    input  logic                                    write_valid_i,
    input  logic [CIPHER_BYTES*payload_pkg::BYTE_W-1:0] cipher_i,
    input  logic [TAG_BYTES*payload_pkg::BYTE_W-1:0]    tag_i,
    byte_fetch_if.store                             fetch
);

    localparam int INDEX_SPAN = 2 ** payload_pkg::INDEX_W;

    logic [CIPHER_BYTES-1:0][payload_pkg::BYTE_W-1:0] cipher_q;
    logic [TAG_BYTES-1:0][payload_pkg::BYTE_W-1:0]    tag_q;

    logic write_accept;

    // a write is taken only between streams
    assign write_accept = write_valid_i && fetch.write_open;

    // both fields load together, byte 0 in the low bits
    always_ff @(posedge clock_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            cipher_q <= '0;
            tag_q <= '0;
        end
        else if (write_accept)
        begin
            cipher_q <= cipher_i;
            tag_q <= tag_i;
        end
    end

    // byte selection, out of range positions read as zero
    always_comb
    begin
        fetch.byte_data = '0;
        if (fetch.field == readout_pkg::FIELD_TAG)
        begin
            if (fetch.index < TAG_BYTES)
            begin
                fetch.byte_data = tag_q[fetch.index];
            end
        end
        else
        begin
            if (fetch.index < CIPHER_BYTES)
            begin
                fetch.byte_data = cipher_q[fetch.index];
            end
        end
    end

    // field lengths must be reachable by the byte index
    if (CIPHER_BYTES > INDEX_SPAN || TAG_BYTES > INDEX_SPAN)
    begin : g_size_check
        $error("field length exceeds byte index range");
    end

    if (CIPHER_BYTES < 1 || TAG_BYTES < 1)
    begin : g_empty_check
        $error("field length must be at least one byte");
    end

    // the readout control never walks past the end of its field
    a_index_in_field : assert property (
        @(posedge clock_i) disable iff (reset_i)
        !fetch.write_open |->
            ((fetch.field == readout_pkg::FIELD_TAG) ? (fetch.index < TAG_BYTES)
                                                     : (fetch.index < CIPHER_BYTES))
    )
    else
    begin
        $error("byte index %0d outside field %s", fetch.index, fetch.field.name());
    end

endmodule : payload_store

// File: hdl/readout_fsm.sv
module readout_fsm
#(
    parameter int CIPHER_BYTES = payload_pkg::DEF_CIPHER_BYTES,
    parameter int TAG_BYTES    = payload_pkg::DEF_TAG_BYTES
)
(
    input  logic                            clock_i,
    input  logic                            reset_i,

    // read request
    input  logic                            read_valid_i,
    input  logic                            write_valid_i,
    input  readout_pkg::field_e             read_field_i,
    output logic                            read_ready_o,

    // byte stream towards the transmitter
    output logic                            byte_valid_o,
    input  logic                            byte_ready_i,
    output logic [payload_pkg::BYTE_W-1:0]  byte_o,
    output logic                            byte_last_o,

    byte_fetch_if.ctrl                      fetch
);

    localparam payload_pkg::byte_index_t CIPHER_LAST =
        payload_pkg::byte_index_t'(CIPHER_BYTES - 1);
    localparam payload_pkg::byte_index_t TAG_LAST =
        payload_pkg::byte_index_t'(TAG_BYTES - 1);

    readout_pkg::readout_state_e    state_q;
    readout_pkg::field_e            field_q;
    payload_pkg::byte_index_t       index_q;

    payload_pkg::byte_index_t       last_index;
    logic                           idle;
    logic                           read_accept;
    logic                           byte_accept;

    assign idle = (state_q == readout_pkg::ST_IDLE);

    // a write offered in the same cycle wins
    assign read_ready_o = idle && !write_valid_i;
    assign read_accept = read_valid_i && read_ready_o;

    assign last_index = (field_q == readout_pkg::FIELD_TAG) ? TAG_LAST : CIPHER_LAST;

    assign byte_valid_o = (state_q == readout_pkg::ST_STREAM);
    assign byte_last_o = byte_valid_o && (index_q == last_index);
    assign byte_accept = byte_valid_o && byte_ready_i;

    // data comes straight from the store, qualified by valid
    assign byte_o = fetch.byte_data;

    assign fetch.field = field_q;
    assign fetch.index = index_q;
    assign fetch.write_open = idle;

    always_ff @(posedge clock_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= readout_pkg::ST_IDLE;
            field_q <= readout_pkg::FIELD_CIPHER;
            index_q <= '0;
        end
        else
        begin
            case (state_q)
                readout_pkg::ST_IDLE:
                begin
                    if (read_accept)
                    begin
                        state_q <= readout_pkg::ST_STREAM;
                        field_q <= read_field_i;
                        index_q <= '0;
                    end
                end

                readout_pkg::ST_STREAM:
                begin
                    if (byte_accept)
                    begin
                        if (byte_last_o)
                        begin
                            state_q <= readout_pkg::ST_IDLE;
                        end
                        else
                        begin
                            index_q <= index_q + 1'b1;
                        end
                    end
                end

                default:
                begin
                    state_q <= readout_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // held byte must not change while the transmitter stalls
    a_stall_holds : assert property (
        @(posedge clock_i) disable iff (reset_i)
        (byte_valid_o && !byte_ready_i) |=>
            (byte_valid_o && $stable(byte_o) && $stable(byte_last_o))
    )
    else
    begin
        $error("byte output changed during stall");
    end

    a_state_known : assert property (
        @(posedge clock_i) disable iff (reset_i)
        !$isunknown(state_q)
    )
    else
    begin
        $error("readout state unknown");
    end

endmodule : readout_fsm

// File: hdl/uart_payload_top.sv
module uart_payload_top
#(
    parameter int CIPHER_BYTES = payload_pkg::DEF_CIPHER_BYTES,
    parameter int TAG_BYTES    = payload_pkg::DEF_TAG_BYTES
)
(
    input  logic                                        clock_i,
    input  logic                                        reset_i,

    // host write of both fields
    input  logic                                        write_valid_i,
    output logic                                        write_ready_o,
    input  logic [CIPHER_BYTES*payload_pkg::BYTE_W-1:0] cipher_i,
    input  logic [TAG_BYTES*payload_pkg::BYTE_W-1:0]    tag_i,

    // read request for one field
    input  logic                                        read_valid_i,
    input  readout_pkg::field_e                         read_field_i,
    output logic                                        read_ready_o,

    // serial byte stream
    output logic                                        byte_valid_o,
    input  logic                                        byte_ready_i,
    output logic [payload_pkg::BYTE_W-1:0]              byte_o,
    output logic                                        byte_last_o
);

    byte_fetch_if fetch_bus ();

    payload_store
    #(
        .CIPHER_BYTES (CIPHER_BYTES),
        .TAG_BYTES    (TAG_BYTES)
    )
    store_i
    (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .write_valid_i (write_valid_i),
        .cipher_i      (cipher_i),
        .tag_i         (tag_i),
        .fetch         (fetch_bus.store)
    );

    readout_fsm
    #(
        .CIPHER_BYTES (CIPHER_BYTES),
        .TAG_BYTES    (TAG_BYTES)
    )
    fsm_i
    (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .read_valid_i  (read_valid_i),
        .write_valid_i (write_valid_i),
        .read_field_i  (read_field_i),
        .read_ready_o  (read_ready_o),
        .byte_valid_o  (byte_valid_o),
        .byte_ready_i  (byte_ready_i),
        .byte_o        (byte_o),
        .byte_last_o   (byte_last_o),
        .fetch         (fetch_bus.ctrl)
    );

    // writes are open exactly when no stream runs
    assign write_ready_o = fetch_bus.write_open;

endmodule : uart_payload_top

// File: bench/tb_payload_table.svh
`ifndef TB_PAYLOAD_TABLE_SVH
`define TB_PAYLOAD_TABLE_SVH

// kinds of table rows
typedef enum logic [1:0]
{
    ROW_WRITE,
    ROW_READ,
    ROW_WRITE_IN_READ
} row_kind_e;

typedef struct packed
{
    row_kind_e              kind;
    readout_pkg::field_e    field;
    logic [7:0]             seed;
    logic                   stall;
} row_t;

localparam int NUM_ROWS = 10;

// kind, field, data seed, random stalls on byte_ready_i
// write rows load both fields, their field entry only sizes the timeout
localparam row_t STIM_TABLE [NUM_ROWS] = '{
    '{ROW_READ,          readout_pkg::FIELD_TAG,    8'h00, 1'b0},
    '{ROW_WRITE,         readout_pkg::FIELD_CIPHER, 8'h17, 1'b0},
    '{ROW_READ,          readout_pkg::FIELD_CIPHER, 8'h00, 1'b0},
    '{ROW_READ,          readout_pkg::FIELD_TAG,    8'h00, 1'b0},
    '{ROW_READ,          readout_pkg::FIELD_CIPHER, 8'h00, 1'b1},
    '{ROW_WRITE_IN_READ, readout_pkg::FIELD_TAG,    8'hc4, 1'b1},
    '{ROW_READ,          readout_pkg::FIELD_CIPHER, 8'h00, 1'b0},
    '{ROW_WRITE,         readout_pkg::FIELD_CIPHER, 8'h9e, 1'b0},
    '{ROW_READ,          readout_pkg::FIELD_TAG,    8'h00, 1'b1},
    '{ROW_READ,          readout_pkg::FIELD_CIPHER, 8'h00, 1'b1}
};

// byte k of a field is the low byte of seed + k * odd step of that field
function automatic logic [7:0] pattern_byte(input logic [7:0] seed,
                                            input readout_pkg::field_e field,
                                            input int k);
    int step;
    step = (field == readout_pkg::FIELD_TAG) ? 101 : 59;
    return 8'(int'(seed) + k * step);
endfunction

`endif

// File: bench/tb_uart_payload.sv
module tb_uart_payload;

    localparam int CIPHER_BYTES = payload_pkg::DEF_CIPHER_BYTES;
    localparam int TAG_BYTES = payload_pkg::DEF_TAG_BYTES;
    localparam int CIPHER_W = CIPHER_BYTES * payload_pkg::BYTE_W;
    localparam int TAG_W = TAG_BYTES * payload_pkg::BYTE_W;

    logic                   clock_i = 1'b0;
    logic                   reset_i;
    logic                   write_valid_i;
    logic                   write_ready_o;
    logic [CIPHER_W-1:0]    cipher_i;
    logic [TAG_W-1:0]       tag_i;
    logic                   read_valid_i;
    readout_pkg::field_e    read_field_i;
    logic                   read_ready_o;
    logic                   byte_valid_o;
    logic                   byte_ready_i;
    logic [7:0]             byte_o;
    logic                   byte_last_o;

    `include "tb_payload_table.svh"

    int         error_count = 0;
    int         cycle_count = 0;
    int         cycle_limit;
    // model of the stored fields, all zero until the first write
    logic       data_written;
    logic [7:0] stored_seed;

    always #2 clock_i = ~clock_i;

    uart_payload_top
    #(
        .CIPHER_BYTES (CIPHER_BYTES),
        .TAG_BYTES    (TAG_BYTES)
    )
    dut_i
    (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o),
        .cipher_i      (cipher_i),
        .tag_i         (tag_i),
        .read_valid_i  (read_valid_i),
        .read_field_i  (read_field_i),
        .read_ready_o  (read_ready_o),
        .byte_valid_o  (byte_valid_o),
        .byte_ready_i  (byte_ready_i),
        .byte_o        (byte_o),
        .byte_last_o   (byte_last_o)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("error at t=%0t: %s", $time, what);
    endtask

    function automatic int field_length(input readout_pkg::field_e field);
        return (field == readout_pkg::FIELD_TAG) ? TAG_BYTES : CIPHER_BYTES;
    endfunction

    function automatic int compute_cycle_limit();
        int total;
        total = 100;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            total += field_length(STIM_TABLE[r].field) * 4;
        end
        return total;
    endfunction

    function automatic logic [7:0] expected_byte(input readout_pkg::field_e field, input int k);
        return data_written ? pattern_byte(stored_seed, field, k) : 8'h00;
    endfunction

    // byte 0 ends up in the low bits
    function automatic logic [CIPHER_W-1:0] cipher_image(input logic [7:0] seed);
        logic [CIPHER_W-1:0] v;
        v = '0;
        for (int k = CIPHER_BYTES - 1; k >= 0; k--)
        begin
            v = {v[CIPHER_W-9:0], pattern_byte(seed, readout_pkg::FIELD_CIPHER, k)};
        end
        return v;
    endfunction

    function automatic logic [TAG_W-1:0] tag_image(input logic [7:0] seed);
        logic [TAG_W-1:0] v;
        v = '0;
        for (int k = TAG_BYTES - 1; k >= 0; k--)
        begin
            v = {v[TAG_W-9:0], pattern_byte(seed, readout_pkg::FIELD_TAG, k)};
        end
        return v;
    endfunction

    // a read is offered alongside to check write priority
    task automatic write_fields(input logic [7:0] seed);
        @(negedge clock_i);
        cipher_i = cipher_image(seed);
        tag_i = tag_image(seed);
        write_valid_i = 1'b1;
        read_valid_i = 1'b1;
        read_field_i = readout_pkg::FIELD_TAG;
        #1;
        while (!write_ready_o)
        begin
            @(negedge clock_i);
            #1;
        end
        check_value("read_ready_o", 32'd0, 32'(read_ready_o));
        @(posedge clock_i);
        data_written = 1'b1;
        stored_seed = seed;
        @(negedge clock_i);
        write_valid_i = 1'b0;
        read_valid_i = 1'b0;
    endtask

    task automatic read_stream(input readout_pkg::field_e field, input logic stall,
                               input logic poke_write, input logic [7:0] poke_seed);
        int len;
        int idx;
        logic finished;
        len = field_length(field);
        idx = 0;
        finished = 1'b0;
        @(negedge clock_i);
        read_valid_i = 1'b1;
        read_field_i = field;
        #1;
        while (!read_ready_o)
        begin
            @(negedge clock_i);
            #1;
        end
        @(negedge clock_i);
        read_valid_i = 1'b0;
        if (poke_write)
        begin
            cipher_i = cipher_image(poke_seed);
            tag_i = tag_image(poke_seed);
            write_valid_i = 1'b1;
        end
        while (!finished)
        begin
            byte_ready_i = stall ? (($urandom % 3) != 0) : 1'b1;
            #1;
            if (!byte_valid_o)
            begin
                report_problem($sformatf("byte_valid_o low before byte %0d of %0d", idx, len));
                finished = 1'b1;
            end
            else
            begin
                // also holds the byte in place during a stall
                check_value("byte_o", 32'(expected_byte(field, idx)), 32'(byte_o));
                check_value("byte_last_o", 32'(idx == len - 1), 32'(byte_last_o));
                check_value("read_ready_o", 32'd0, 32'(read_ready_o));
                if (poke_write)
                begin
                    check_value("write_ready_o", 32'd0, 32'(write_ready_o));
                end
                if (byte_ready_i)
                begin
                    idx++;
                    finished = (idx >= len);
                end
            end
            @(negedge clock_i);
        end
        write_valid_i = 1'b0;
        byte_ready_i = 1'b0;
        #1;
        check_value("byte_valid_o", 32'd0, 32'(byte_valid_o));
        check_value("read_ready_o", 32'd1, 32'(read_ready_o));
        check_value("write_ready_o", 32'd1, 32'(write_ready_o));
    endtask

    task automatic run_row(input row_t row);
        case (row.kind)
            ROW_WRITE:         write_fields(row.seed);
            ROW_READ:          read_stream(row.field, row.stall, 1'b0, 8'h00);
            ROW_WRITE_IN_READ: read_stream(row.field, row.stall, 1'b1, row.seed);
            default:           report_problem("unknown row kind in stimulus table");
        endcase
    endtask

    always @(posedge clock_i)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            $display("errors: %0d", error_count + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(32'h4a7f));
        cycle_limit = compute_cycle_limit();
        reset_i = 1'b1;
        write_valid_i = 1'b0;
        cipher_i = '0;
        tag_i = '0;
        read_valid_i = 1'b0;
        read_field_i = readout_pkg::FIELD_CIPHER;
        byte_ready_i = 1'b0;
        data_written = 1'b0;
        stored_seed = 8'h00;
        repeat (2) @(posedge clock_i);
        @(negedge clock_i);
        reset_i = 1'b0;
        #1;
        check_value("byte_valid_o", 32'd0, 32'(byte_valid_o));
        check_value("byte_last_o", 32'd0, 32'(byte_last_o));
        check_value("write_ready_o", 32'd1, 32'(write_ready_o));
        check_value("read_ready_o", 32'd1, 32'(read_ready_o));
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            run_row(STIM_TABLE[r]);
        end
        $display("errors: %0d", error_count);
        if (error_count == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_uart_payload

// File: files.f
+incdir+bench
hdl/payload_pkg.sv
hdl/readout_pkg.sv
hdl/byte_fetch_if.sv
hdl/payload_store.sv
hdl/readout_fsm.sv
hdl/uart_payload_top.sv
bench/tb_uart_payload.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_uart_payload
FILELIST  = files.f
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
